/* verilog/apple1_bus_defs.svh */
//######################################################################
// apple-1 bus glue shared constants
// address map bounds, bus widths, memory index widths, dac width
//######################################################################
`ifndef APPLE1_BUS_DEFS_SVH
`define APPLE1_BUS_DEFS_SVH

// bus widths
`define A1_ADDR_BITS 16
`define A1_DATA_BITS 8

// address map
`define A1_RAM_LO_END 16'h3FFF   // low ram is 0x0000 up to here
`define A1_ACI_BASE   16'hC000   // cassette interface
`define A1_ACI_END    16'hC1FF
`define A1_BASIC_BASE 16'hE000   // basic ram
`define A1_BASIC_END  16'hEFFF
`define A1_ROM_BASE   16'hFF00   // wozmon rom up to 0xFFFF

// memory index widths
`define A1_RAM_LO_AW 14          // 16 KiB
`define A1_BASIC_AW  12          // 4 KiB
`define A1_ROM_AW    8           // 256 bytes

// tape monitor sigma-delta accumulator
`define A1_DAC_BITS 16

`endif

/* verilog/apple1_bus_pkg.sv */
//######################################################################
// apple-1 bus glue types
// byte, address and address-map region
//######################################################################
`include "apple1_bus_defs.svh"

package apple1_bus_pkg;

	typedef logic [`A1_DATA_BITS-1:0] byte_t;  // one data byte
	typedef logic [`A1_ADDR_BITS-1:0] addr_t;  // one cpu address

	// which part of the map an address hits
	typedef enum logic [2:0] {
		REG_NONE   = 3'd0,  // unmapped, reads as zero
		REG_RAM_LO = 3'd1,
		REG_ACI    = 3'd2,
		REG_BASIC  = 3'd3,
		REG_ROM    = 3'd4
	} region_e;

endpackage

/* verilog/apple1_bus_mem.sv */
//######################################################################
// synchronous single-port byte memory
// registered read, old data on a same-cycle write
//######################################################################
`timescale 1ns/1ps
`include "apple1_bus_defs.svh"

module apple1_bus_mem #(
	parameter int ADDR_W = 8  // index width, depth is 2**ADDR_W
) (
	input  logic                     sys_clock,
	input  logic [ADDR_W-1:0]        addr_i,
	input  logic                     wr_i,
	input  logic [`A1_DATA_BITS-1:0] data_i,
	output logic [`A1_DATA_BITS-1:0] data_o
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [`A1_DATA_BITS-1:0] mem_q [0:DEPTH-1];
	logic [`A1_DATA_BITS-1:0] rd_q;

	always_ff @(posedge sys_clock) begin
		if (wr_i) begin
			mem_q[addr_i] <= data_i;
		end
		rd_q <= mem_q[addr_i];  // read before write
	end

	assign data_o = rd_q;

endmodule

/* verilog/apple1_bus_decode.sv */
//######################################################################
// apple-1 bus source arbitration and address-map decode
// download port wins over the cpu on a download write
//######################################################################
`timescale 1ns/1ps
`include "apple1_bus_defs.svh"

module apple1_bus_decode (
	input  logic                    sys_clock,
	input  logic                    reset_i,
	input  apple1_bus_pkg::addr_t   cpu_addr_i,
	input  apple1_bus_pkg::byte_t   cpu_data_i,
	input  logic                    cpu_wr_i,
	input  logic                    dl_active_i,
	input  logic                    dl_wr_i,
	input  apple1_bus_pkg::addr_t   dl_addr_i,
	input  apple1_bus_pkg::byte_t   dl_data_i,
	output apple1_bus_pkg::addr_t   bus_addr_o,
	output apple1_bus_pkg::byte_t   bus_data_o,
	output logic                    bus_wr_o,
	output logic                    bus_from_dl_o,
	output apple1_bus_pkg::region_e bus_region_o
);
	import apple1_bus_pkg::*;

	logic dl_take;  // download write this cycle

	assign dl_take = dl_active_i & dl_wr_i;

	// cpu write in a download cycle is dropped
	assign bus_addr_o    = dl_take ? dl_addr_i : cpu_addr_i;
	assign bus_data_o    = dl_take ? dl_data_i : cpu_data_i;
	assign bus_wr_o      = dl_take ? 1'b1      : cpu_wr_i;
	assign bus_from_dl_o = dl_take;

	// classify the chosen address
	always_comb begin
		if (bus_addr_o <= `A1_RAM_LO_END) begin
			bus_region_o = REG_RAM_LO;
		end else if (bus_addr_o >= `A1_ACI_BASE && bus_addr_o <= `A1_ACI_END) begin
			bus_region_o = REG_ACI;
		end else if (bus_addr_o >= `A1_BASIC_BASE && bus_addr_o <= `A1_BASIC_END) begin
			bus_region_o = REG_BASIC;
		end else if (bus_addr_o >= `A1_ROM_BASE) begin
			bus_region_o = REG_ROM;  // top page
		end else begin
			// 0x4000-0xBFFF (no sdram here), 0xC200-0xDFFF, 0xF000-0xFEFF
			bus_region_o = REG_NONE;
		end
	end

endmodule

/* verilog/apple1_bus_execute.sv */
//######################################################################
// apple-1 bus execute stage
// low ram, basic ram and monitor rom banks with region write gating
// cassette interface: tape-in latch, tape-out flip-flop, status byte
//######################################################################
`timescale 1ns/1ps
`include "apple1_bus_defs.svh"

module apple1_bus_execute (
	input  logic                    sys_clock,
	input  logic                    reset_i,
	input  apple1_bus_pkg::addr_t   bus_addr_i,
	input  apple1_bus_pkg::byte_t   bus_data_i,
	input  logic                    bus_wr_i,
	input  logic                    bus_from_dl_i,
	input  apple1_bus_pkg::region_e bus_region_i,
	input  logic                    tape_rx_i,
	output apple1_bus_pkg::byte_t   ram_lo_rd_o,
	output apple1_bus_pkg::byte_t   basic_rd_o,
	output apple1_bus_pkg::byte_t   rom_rd_o,
	output apple1_bus_pkg::byte_t   aci_rd_o,
	output logic                    tape_out_o
);
	import apple1_bus_pkg::*;

	logic  ram_lo_we;
	logic  basic_we;
	logic  rom_we;
	logic  aci_we;
	logic  tape_in_q;   // latched cassette input
	logic  tape_out_q;  // cassette output flip-flop
	byte_t aci_rd_q;

	// per-region write strobes
	assign ram_lo_we = bus_wr_i & (bus_region_i == REG_RAM_LO);
	assign basic_we  = bus_wr_i & (bus_region_i == REG_BASIC);
	assign rom_we    = bus_wr_i & bus_from_dl_i & (bus_region_i == REG_ROM);  // loader only
	assign aci_we    = bus_wr_i & (bus_region_i == REG_ACI);

	apple1_bus_mem #(.ADDR_W(`A1_RAM_LO_AW)) ram_lo_mem (
		.sys_clock (sys_clock),
		.addr_i    (bus_addr_i[`A1_RAM_LO_AW-1:0]),
		.wr_i      (ram_lo_we),
		.data_i    (bus_data_i),
		.data_o    (ram_lo_rd_o)
	);

	apple1_bus_mem #(.ADDR_W(`A1_BASIC_AW)) basic_mem (
		.sys_clock (sys_clock),
		.addr_i    (bus_addr_i[`A1_BASIC_AW-1:0]),
		.wr_i      (basic_we),
		.data_i    (bus_data_i),
		.data_o    (basic_rd_o)
	);

	// wozmon image arrives through the download port
	apple1_bus_mem #(.ADDR_W(`A1_ROM_AW)) rom_mem (
		.sys_clock (sys_clock),
		.addr_i    (bus_addr_i[`A1_ROM_AW-1:0]),
		.wr_i      (rom_we),
		.data_i    (bus_data_i),
		.data_o    (rom_rd_o)
	);

	// cassette interface state
	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			tape_in_q  <= 1'b0;
			tape_out_q <= 1'b0;
			aci_rd_q   <= '0;
		end else begin
			tape_in_q <= ~tape_rx_i;  // line is inverted
			if (aci_we) begin
				tape_out_q <= ~tape_out_q;  // any write toggles
			end
			// status sampled like a memory read, one cycle late
			aci_rd_q <= {6'b0, tape_out_q, tape_in_q};
		end
	end

	assign aci_rd_o   = aci_rd_q;
	assign tape_out_o = tape_out_q;

endmodule

/* verilog/apple1_bus_result.sv */
//######################################################################
// apple-1 bus result stage
// read-data select on the registered region, tape monitor dac
//######################################################################
`timescale 1ns/1ps
`include "apple1_bus_defs.svh"

module apple1_bus_result (
	input  logic                    sys_clock,
	input  logic                    reset_i,
	input  apple1_bus_pkg::region_e bus_region_i,
	input  apple1_bus_pkg::byte_t   ram_lo_rd_i,
	input  apple1_bus_pkg::byte_t   basic_rd_i,
	input  apple1_bus_pkg::byte_t   rom_rd_i,
	input  apple1_bus_pkg::byte_t   aci_rd_i,
	input  logic                    mon_tape_in_i,
	output apple1_bus_pkg::byte_t   cpu_data_o,
	output logic                    audio_o
);
	import apple1_bus_pkg::*;

	localparam logic [`A1_DAC_BITS-1:0] DAC_HALF = 1 << (`A1_DAC_BITS - 1);

	region_e                  region_q;  // lines up with memory read data
	logic                     mon_bit;
	logic [`A1_DAC_BITS-1:0]  dac_step;
	logic [`A1_DAC_BITS-1:0]  dac_acc_q;
	logic [`A1_DAC_BITS:0]    dac_sum;   // carry in the top bit
	logic                     audio_q;

	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			region_q <= REG_NONE;
		end else begin
			region_q <= bus_region_i;
		end
	end

	// read byte select
	always_comb begin
		case (region_q)
			REG_RAM_LO: cpu_data_o = ram_lo_rd_i;
			REG_BASIC:  cpu_data_o = basic_rd_i;
			REG_ROM:    cpu_data_o = rom_rd_i;
			REG_ACI:    cpu_data_o = aci_rd_i;
			default:    cpu_data_o = '0;  // unmapped
		endcase
	end

	// monitor source, tape-in latch or tape-out flip-flop
	assign mon_bit  = mon_tape_in_i ? aci_rd_i[0] : aci_rd_i[1];
	assign dac_step = mon_bit ? DAC_HALF : '0;
	assign dac_sum  = {1'b0, dac_acc_q} + {1'b0, dac_step};

	// first-order sigma-delta, carry is the bitstream
	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			dac_acc_q <= '0;
			audio_q   <= 1'b0;
		end else begin
			dac_acc_q <= dac_sum[`A1_DAC_BITS-1:0];
			audio_q   <= dac_sum[`A1_DAC_BITS];
		end
	end

	assign audio_o = audio_q;

endmodule

/* verilog/apple1_bus_top.sv */
//######################################################################
// apple-1 system bus glue top level
// decode, execute, result stages, reset key edge, download led
//######################################################################
`timescale 1ns/1ps

module apple1_bus_top (
	input  logic                  sys_clock,
	input  logic                  reset_i,
	input  apple1_bus_pkg::addr_t cpu_addr_i,
	input  apple1_bus_pkg::byte_t cpu_data_i,
	input  logic                  cpu_wr_i,
	input  logic                  dl_active_i,
	input  logic                  dl_wr_i,
	input  apple1_bus_pkg::addr_t dl_addr_i,
	input  apple1_bus_pkg::byte_t dl_data_i,
	input  logic                  tape_rx_i,
	input  logic                  mon_tape_in_i,   // 1 tape-in, 0 tape-out
	input  logic                  reset_key_i,
	output apple1_bus_pkg::byte_t cpu_data_o,
	output logic                  tape_out_o,
	output logic                  audio_o,
	output logic                  led_o,           // low while downloading
	output logic                  cpu_reset_o
);
	import apple1_bus_pkg::*;

	addr_t   bus_addr;
	byte_t   bus_data;
	logic    bus_wr;
	logic    bus_from_dl;
	region_e bus_region;
	byte_t   ram_lo_rd;
	byte_t   basic_rd;
	byte_t   rom_rd;
	byte_t   aci_rd;
	logic    reset_key_q;  // key level one cycle back

	// a held key must not keep the cpu in reset
	always_ff @(posedge sys_clock) begin
		reset_key_q <= reset_key_i;
	end

	assign cpu_reset_o = reset_i | (reset_key_i & ~reset_key_q);
	assign led_o       = ~bus_from_dl;

	apple1_bus_decode decode_i (
		.sys_clock     (sys_clock),
		.reset_i       (reset_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_data_i    (cpu_data_i),
		.cpu_wr_i      (cpu_wr_i),
		.dl_active_i   (dl_active_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.bus_addr_o    (bus_addr),
		.bus_data_o    (bus_data),
		.bus_wr_o      (bus_wr),
		.bus_from_dl_o (bus_from_dl),
		.bus_region_o  (bus_region)
	);

	apple1_bus_execute execute_i (
		.sys_clock     (sys_clock),
		.reset_i       (reset_i),
		.bus_addr_i    (bus_addr),
		.bus_data_i    (bus_data),
		.bus_wr_i      (bus_wr),
		.bus_from_dl_i (bus_from_dl),
		.bus_region_i  (bus_region),
		.tape_rx_i     (tape_rx_i),
		.ram_lo_rd_o   (ram_lo_rd),
		.basic_rd_o    (basic_rd),
		.rom_rd_o      (rom_rd),
		.aci_rd_o      (aci_rd),
		.tape_out_o    (tape_out_o)
	);

	apple1_bus_result result_i (
		.sys_clock     (sys_clock),
		.reset_i       (reset_i),
		.bus_region_i  (bus_region),
		.ram_lo_rd_i   (ram_lo_rd),
		.basic_rd_i    (basic_rd),
		.rom_rd_i      (rom_rd),
		.aci_rd_i      (aci_rd),
		.mon_tape_in_i (mon_tape_in_i),
		.cpu_data_o    (cpu_data_o),
		.audio_o       (audio_o)
	);

endmodule

/* test/apple1_bus_checker.sv */
//######################################################################
// bound assertions on the apple-1 bus glue top level
// download led, unmapped reads, silent tape monitor
//######################################################################
`timescale 1ns/1ps

module apple1_bus_checker (
	input logic                    sys_clock,
	input logic                    reset_i,
	input logic                    dl_active_i,
	input logic                    dl_wr_i,
	input logic                    led_i,
	input apple1_bus_pkg::region_e bus_region_i,
	input apple1_bus_pkg::byte_t   cpu_data_i,
	input apple1_bus_pkg::byte_t   aci_rd_i,
	input logic                    mon_tape_in_i,
	input logic                    audio_i
);
	import apple1_bus_pkg::*;

	logic mon_bit;       // same bit the dac integrates
	logic quiet_q;       // monitored bit stayed 0 since the dac cleared
	int   fail_cnt = 0;  // failed assertion count

	assign mon_bit = mon_tape_in_i ? aci_rd_i[0] : aci_rd_i[1];

	always_ff @(posedge sys_clock) begin
		if (reset_i) begin
			quiet_q <= 1'b1;
		end else if (mon_bit) begin
			quiet_q <= 1'b0;
		end
	end

	led_tracks_download: assert property (@(posedge sys_clock)
		led_i == !(dl_active_i && dl_wr_i))
		else begin
			$error("led_o does not match the download write state");
			fail_cnt++;
		end

	unmapped_reads_zero: assert property (@(posedge sys_clock) disable iff (reset_i)
		bus_region_i == REG_NONE |=> cpu_data_i == '0)
		else begin
			$error("unmapped read returned nonzero data");
			fail_cnt++;
		end

	silent_audio: assert property (@(posedge sys_clock) disable iff (reset_i)
		quiet_q |-> !audio_i)
		else begin
			$error("audio_o pulsed while the monitored bit stayed 0");
			fail_cnt++;
		end

endmodule

bind apple1_bus_top apple1_bus_checker checker_i (
	.sys_clock     (sys_clock),
	.reset_i       (reset_i),
	.dl_active_i   (dl_active_i),
	.dl_wr_i       (dl_wr_i),
	.led_i         (led_o),
	.bus_region_i  (bus_region),
	.cpu_data_i    (cpu_data_o),
	.aci_rd_i      (aci_rd),
	.mon_tape_in_i (mon_tape_in_i),
	.audio_i       (audio_o)
);

/* test/apple1_bus_tb.sv */
//######################################################################
// apple-1 bus glue testbench
// random cpu and download traffic against a shadow model
// read data, led, cpu reset, tape and audio checks
//######################################################################
`timescale 1ns/1ps
`include "apple1_bus_defs.svh"

module apple1_bus_tb;

	// cycles per test in test order, reset and margin on top
	localparam int TEST_CYCLES = 96 + 96 + 48 + 32 + 173 + 16;
	localparam int CYCLE_LIMIT = 10 + TEST_CYCLES + 200;

	logic                     sys_clock = 1'b0;
	logic                     reset_i;
	logic [`A1_ADDR_BITS-1:0] cpu_addr_i;
	logic [`A1_DATA_BITS-1:0] cpu_data_i;
	logic                     cpu_wr_i;
	logic                     dl_active_i;
	logic                     dl_wr_i;
	logic [`A1_ADDR_BITS-1:0] dl_addr_i;
	logic [`A1_DATA_BITS-1:0] dl_data_i;
	logic                     tape_rx_i;
	logic                     mon_tape_in_i;
	logic                     reset_key_i;
	logic [`A1_DATA_BITS-1:0] cpu_data_o;
	logic                     tape_out_o;
	logic                     audio_o;
	logic                     led_o;
	logic                     cpu_reset_o;

	integer                   seed = 32'h57315f41;
	int                       errors = 0;
	int                       checks = 0;
	int                       cycle_cnt = 0;
	int                       key_pulses = 0;   // cpu reset cycles seen
	logic [`A1_DATA_BITS-1:0] mem_m [int];      // all three memories by bus address
	logic                     tape_in_m = 1'b0;
	logic                     tape_out_m = 1'b0;
	logic                     key_prev_m = 1'b0;
	logic [`A1_ADDR_BITS-1:0] wr_q [$];         // download targets

	apple1_bus_top apple1_bus_top_i (.*);

	always #5 sys_clock = ~sys_clock;

	always @(posedge sys_clock) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, tests did not finish", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// 0 none, 1 low ram, 2 aci, 3 basic, 4 rom
	function automatic int region_of(input logic [15:0] a);
		if (a <= `A1_RAM_LO_END) return 1;
		if (a >= `A1_ACI_BASE && a <= `A1_ACI_END) return 2;
		if (a >= `A1_BASIC_BASE && a <= `A1_BASIC_END) return 3;
		if (a >= `A1_ROM_BASE) return 4;
		return 0;
	endfunction

	// random address inside low ram, basic ram or rom
	function automatic logic [15:0] mem_addr(input int sel);
		logic [31:0] r;
		r = rand_word();
		case (sel)
			0: return {2'b00, r[13:0]};
			1: return {4'hE, r[11:0]};
			default: return {8'hFF, r[7:0]};
		endcase
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// one bus cycle, entered 1 ns after the rising edge
	task automatic drive_cycle(input logic [15:0] c_addr, input logic [7:0] c_data,
		input logic c_wr, input logic d_wr, input logic [15:0] d_addr,
		input logic [7:0] d_data, input string name);
		logic        take;
		logic [15:0] a;
		int          reg_n;
		logic [7:0]  exp_rd;
		logic        known;
		cpu_addr_i = c_addr;
		cpu_data_i = c_data;
		cpu_wr_i   = c_wr;
		dl_wr_i    = d_wr;
		dl_addr_i  = d_addr;
		dl_data_i  = d_data;
		take   = dl_active_i & d_wr;  // download write owns the bus
		a      = take ? d_addr : c_addr;
		reg_n  = region_of(a);
		exp_rd = 8'h00;               // unmapped
		known  = 1'b1;
		if (reg_n == 2) begin
			exp_rd = {6'b0, tape_out_m, tape_in_m};
		end else if (reg_n != 0) begin
			known  = mem_m.exists(a);  // unwritten bytes are unknown
			exp_rd = known ? mem_m[a] : 8'h00;
		end
		#4;
		check_byte({name, " led"}, {7'b0, ~take}, {7'b0, led_o});
		check_byte({name, " cpu reset"}, {7'b0, reset_key_i & ~key_prev_m}, {7'b0, cpu_reset_o});
		if (cpu_reset_o) begin
			key_pulses++;
		end
		// rom takes download writes only
		if ((take | c_wr) && (reg_n == 1 || reg_n == 3 || (reg_n == 4 && take))) begin
			mem_m[a] = take ? d_data : c_data;
		end
		if ((take | c_wr) && reg_n == 2) begin
			tape_out_m = ~tape_out_m;
		end
		tape_in_m  = ~tape_rx_i;
		key_prev_m = reset_key_i;
		@(posedge sys_clock);
		#1;
		if (known) begin
			check_byte({name, " read"}, exp_rd, cpu_data_o);
		end
		check_byte({name, " tape out"}, {7'b0, tape_out_m}, {7'b0, tape_out_o});
	endtask

	task automatic idle_cycles(input int n, input string name);
		repeat (n) begin
			drive_cycle(16'h4000, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, name);
		end
	endtask

	task automatic check_audio(input string name, input int n, input int lo, input int hi);
		int highs;
		highs = 0;
		repeat (n) begin
			idle_cycles(1, name);
			if (audio_o) begin
				highs++;
			end
		end
		checks++;
		if (highs < lo || highs > hi) begin
			errors++;
			$display("Mismatch %s: expected %0d to %0d high cycles, actual %0d", name, lo, hi, highs);
		end
	endtask

	initial begin
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] r;
		reset_i       = 1'b1;
		cpu_addr_i    = '0;
		cpu_data_i    = '0;
		cpu_wr_i      = 1'b0;
		dl_active_i   = 1'b0;
		dl_wr_i       = 1'b0;
		dl_addr_i     = '0;
		dl_data_i     = '0;
		tape_rx_i     = 1'b0;
		mon_tape_in_i = 1'b0;
		reset_key_i   = 1'b0;
		repeat (10) @(posedge sys_clock);
		#1;
		// state at the end of reset, cpu held in reset
		check_byte("reset cpu reset", 8'h01, {7'b0, cpu_reset_o});
		check_byte("reset read", 8'h00, cpu_data_o);
		check_byte("reset tape out", 8'h00, {7'b0, tape_out_o});
		check_byte("reset audio", 8'h00, {7'b0, audio_o});
		check_byte("reset led", 8'h01, {7'b0, led_o});
		reset_i = 1'b0;

		// download into all three memories, then cpu readback
		dl_active_i = 1'b1;
		repeat (48) begin
			a = mem_addr(rand_word() % 3);
			r = rand_word();
			drive_cycle(mem_addr(0), r[7:0], 1'b0, r[8], a, r[15:8], "download");
			if (r[8]) begin
				wr_q.push_back(a);
			end
		end
		foreach (wr_q[i]) begin
			drive_cycle(wr_q[i], 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, "download readback");
		end

		// arbitration, rom protection, ram read-after-write
		repeat (16) begin
			a = mem_addr(rand_word() % 2);
			b = mem_addr(2);
			r = rand_word();
			drive_cycle(a, r[7:0], 1'b1, 1'b0, 16'h0000, 8'h00, "cpu write");
			drive_cycle(a, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, "cpu readback");
			drive_cycle(a, r[15:8], 1'b1, 1'b1, b, r[23:16], "arbitration");
			drive_cycle(a, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, "lost cpu write");
			drive_cycle(b, r[31:24], 1'b1, 1'b0, 16'h0000, 8'h00, "rom write");
			drive_cycle(b, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, "rom protect");
		end
		dl_active_i = 1'b0;

		// holes in the map
		repeat (48) begin
			r = rand_word();
			case (r[1:0])
				2'd0: a = 16'h4000 + {1'b0, r[16:2]};
				2'd1: a = 16'hC200 + 16'(r[31:2] % 32'h1E00);
				default: a = 16'hF000 + 16'(r[31:2] % 32'h0F00);
			endcase
			drive_cycle(a, r[23:16], r[24], 1'b0, 16'h0000, 8'h00, "unmapped read");
		end

		// cassette interface
		repeat (8) begin
			r = rand_word();
			a = {7'b1100000, r[9:1]};
			tape_rx_i = r[0];
			idle_cycles(1, "tape settle");
			drive_cycle(a, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, "aci tape in");
			drive_cycle(a, r[17:10], 1'b1, 1'b0, 16'h0000, 8'h00, "aci write");
			drive_cycle(a, 8'h00, 1'b0, 1'b0, 16'h0000, 8'h00, "aci tape out");
		end

		// tape monitor, bit at 1 via tape-in, then tape-out, then bit at 0
		mon_tape_in_i = 1'b1;
		tape_rx_i     = 1'b0;
		idle_cycles(4, "audio settle");
		check_audio("audio tape-in", 64, 31, 33);
		if (!tape_out_m) begin
			drive_cycle(16'hC000, 8'h00, 1'b1, 1'b0, 16'h0000, 8'h00, "aci write");
		end
		mon_tape_in_i = 1'b0;
		idle_cycles(4, "audio settle");
		check_audio("audio tape-out", 64, 31, 33);
		mon_tape_in_i = 1'b1;
		tape_rx_i     = 1'b1;
		idle_cycles(4, "audio settle");
		check_audio("audio silent", 32, 0, 0);

		// reset key, two presses
		reset_key_i = 1'b1;
		idle_cycles(6, "reset key held");
		reset_key_i = 1'b0;
		idle_cycles(3, "reset key released");
		reset_key_i = 1'b1;
		idle_cycles(4, "reset key again");
		reset_key_i = 1'b0;
		idle_cycles(3, "reset key released");
		check_byte("reset key pulses", 8'd2, 8'(key_pulses));

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			apple1_bus_top_i.checker_i.fail_cnt);
		if (errors == 0 && apple1_bus_top_i.checker_i.fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* apple1_bus.f */
+incdir+verilog
verilog/apple1_bus_pkg.sv
verilog/apple1_bus_mem.sv
verilog/apple1_bus_decode.sv
verilog/apple1_bus_execute.sv
verilog/apple1_bus_result.sv
verilog/apple1_bus_top.sv
test/apple1_bus_checker.sv
test/apple1_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the apple-1 bus glue testbench with verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f apple1_bus.f --top-module apple1_bus_tb -o apple1_bus_sim

./obj_dir/apple1_bus_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	echo "simulation ended without a closing message"
	exit 1
fi
